// File: hdl/free_list.sv
`timescale 1ns/100ps

module free_list (
   input  logic                                          clk,
   input  logic                                          rst_n,
   rename_group_if.rename                                grp,
   input  rename_pkg::free_bundle_t                      free_i,
   output rename_pkg::phys_t [rename_pkg::NUM_SLOTS-1:0] alloc_o,
   output logic                                          short_o
);

   rename_pkg::phys_t list_q [rename_pkg::NUM_PHYS];
   rename_pkg::ptr_t  alloc_ptr_q;
   rename_pkg::ptr_t  rel_ptr_q;
   rename_pkg::ptr_t  free_cnt;
   rename_pkg::phys_t alloc_base;
   rename_pkg::phys_t rel_base;
   rename_pkg::phys_t offs [rename_pkg::NUM_SLOTS];
   logic [2:0]        need_cnt;

   function automatic logic [2:0] ones(input logic [rename_pkg::NUM_SLOTS-1:0] m);
      logic [2:0] n;
      n = '0;
      for (int i = 0; i < rename_pkg::NUM_SLOTS; i++)
      begin
         if (m[i])
            n = n + 3'd1;
      end
      return n;
   endfunction

   assign alloc_base = rename_pkg::phys_t'(alloc_ptr_q);
   assign rel_base   = rename_pkg::phys_t'(rel_ptr_q);
   assign need_cnt   = ones(grp.need);

   // each needing slot skips the entries taken by earlier needing slots
   always_comb
   begin
      for (int k = 0; k < rename_pkg::NUM_SLOTS; k++)
      begin
         offs[k]    = rename_pkg::phys_t'(ones(grp.need & ((4'd1 << k) - 4'd1)));
         alloc_o[k] = list_q[alloc_base + offs[k]];
      end
   end

   // wrap bits make a full list read as 64 rather than 0
   assign free_cnt = rel_ptr_q + rename_pkg::ptr_t'(rename_pkg::NUM_PHYS) - alloc_ptr_q;
   assign short_o  = free_cnt < rename_pkg::ptr_t'(rename_pkg::NUM_SLOTS);

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         // physical 0..15 start out mapped, so allocation begins past them
         alloc_ptr_q <= rename_pkg::ptr_t'(rename_pkg::NUM_ARCH);
         rel_ptr_q   <= '0;
      end
      else
      begin
         if (grp.fire)
            alloc_ptr_q <= alloc_ptr_q + rename_pkg::ptr_t'(need_cnt);
         rel_ptr_q <= rel_ptr_q + rename_pkg::ptr_t'(free_i.count);
      end
   end

   // list contents start as the identity
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < rename_pkg::NUM_PHYS; i++)
            list_q[i] <= rename_pkg::phys_t'(i);
      end
      else
      begin
         for (int k = 0; k < rename_pkg::NUM_SLOTS; k++)
         begin
            if (3'(k) < free_i.count)
               list_q[rel_base + rename_pkg::phys_t'(k)] <= free_i.entry[k];
         end
      end
   end

   // more than 64 free means a register came back twice
   a_free_bounded: assert property (@(posedge clk) disable iff (!rst_n)
      free_cnt <= rename_pkg::ptr_t'(rename_pkg::NUM_PHYS))
      else $error("free count above %0d", rename_pkg::NUM_PHYS);

endmodule

// File: hdl/map_table.sv
`timescale 1ns/100ps

module map_table (
   input  logic                                          clk,
   input  logic                                          rst_n,
   rename_group_if.rename                                grp,
   input  rename_pkg::phys_t [rename_pkg::NUM_SLOTS-1:0] alloc_i,
   output rename_pkg::group_out_t                        group_o
);

   rename_pkg::phys_t map_q [rename_pkg::NUM_ARCH];

   // lookups see the table plus earlier slots of the same group
   always_comb
   begin
      rename_pkg::phys_t s0;
      rename_pkg::phys_t s1;
      rename_pkg::phys_t od;
      for (int k = 0; k < rename_pkg::NUM_SLOTS; k++)
      begin
         s0 = map_q[grp.slots[k].src0];
         s1 = map_q[grp.slots[k].src1];
         od = map_q[grp.slots[k].dst];
         // ascending order so the newest earlier writer wins
         for (int j = 0; j < rename_pkg::NUM_SLOTS; j++)
         begin
            if (j < k && grp.need[j])
            begin
               if (grp.slots[j].dst == grp.slots[k].src0)
                  s0 = alloc_i[j];
               if (grp.slots[j].dst == grp.slots[k].src1)
                  s1 = alloc_i[j];
               if (grp.slots[j].dst == grp.slots[k].dst)
                  od = alloc_i[j];
            end
         end
         group_o[k].valid   = grp.slots[k].valid;
         group_o[k].has_dst = grp.slots[k].has_dst;
         group_o[k].new_dst = grp.need[k] ? alloc_i[k] : '0;
         group_o[k].old_dst = grp.need[k] ? od : '0;
         group_o[k].src0    = s0;
         group_o[k].src1    = s1;
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int r = 0; r < rename_pkg::NUM_ARCH; r++)
            map_q[r] <= rename_pkg::phys_t'(r);
      end
      else if (grp.fire)
      begin
         // later slot overrides on the same register
         for (int k = 0; k < rename_pkg::NUM_SLOTS; k++)
         begin
            if (grp.need[k])
               map_q[grp.slots[k].dst] <= alloc_i[k];
         end
      end
   end

endmodule

// File: hdl/rename_group_if.sv
`timescale 1ns/100ps

interface rename_group_if;

   // registered group held by the intake
   rename_pkg::slot_in_t [rename_pkg::NUM_SLOTS-1:0] slots;

   // slots that are valid and write a destination
   logic [rename_pkg::NUM_SLOTS-1:0] need;

   // one cycle, allocation and map write happen at the next edge
   logic fire;

   modport intake (
      output slots,
      output need,
      output fire
   );

   modport rename (
      input slots,
      input need,
      input fire
   );

endinterface

// File: hdl/rename_intake.sv
`timescale 1ns/100ps

module rename_intake (
   input  logic                                             clk,
   input  logic                                             rst_n,
   input  logic                                             group_valid_i,
   input  rename_pkg::slot_in_t [rename_pkg::NUM_SLOTS-1:0] slots_i,
   input  logic [rename_pkg::NUM_SLOTS-1:0]                 retire_valid_i,
   input  rename_pkg::phys_t [rename_pkg::NUM_SLOTS-1:0]    retire_phys_i,
   input  logic                                             short_i,
   input  logic                                             full_i,
   output logic                                             hold_o,
   output rename_pkg::free_bundle_t                         free_o,
   rename_group_if.intake                                   grp
);

   logic                                             occ_q;
   logic                                             fire_q;
   logic                                             take;
   rename_pkg::slot_in_t [rename_pkg::NUM_SLOTS-1:0] slots_q;
   logic [rename_pkg::NUM_SLOTS-1:0]                 ret_valid_q;
   rename_pkg::phys_t [rename_pkg::NUM_SLOTS-1:0]    ret_phys_q;

   // busy from sampling until the fire cycle
   assign hold_o = occ_q && !fire_q;
   assign take   = group_valid_i && !hold_o;

   // fire is decided one cycle ahead; the list and buffer can only
   // gain room in between, since nothing else allocates or pushes
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         occ_q  <= 1'b0;
         fire_q <= 1'b0;
      end
      else
      begin
         fire_q <= occ_q && !fire_q && !short_i && !full_i;
         if (take)
            occ_q <= 1'b1;
         else if (fire_q)
            occ_q <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (take)
         slots_q <= slots_i;
   end

   assign grp.slots = slots_q;
   assign grp.fire  = fire_q;

   always_comb
   begin
      for (int k = 0; k < rename_pkg::NUM_SLOTS; k++)
         grp.need[k] = slots_q[k].valid && slots_q[k].has_dst;
   end

   // retire port, sampled every cycle
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         ret_valid_q <= '0;
      else
         ret_valid_q <= retire_valid_i;
   end

   always_ff @(posedge clk)
   begin
      ret_phys_q <= retire_phys_i;
   end

   // squeeze out the holes, lowest slot first
   always_comb
   begin
      logic [2:0] pos;
      pos          = '0;
      free_o.entry = '0;
      for (int k = 0; k < rename_pkg::NUM_SLOTS; k++)
      begin
         if (ret_valid_q[k])
         begin
            free_o.entry[pos[1:0]] = ret_phys_q[k];
            pos = pos + 3'd1;
         end
      end
      free_o.count = pos;
   end

   a_fire_not_short: assert property (@(posedge clk) disable iff (!rst_n)
      grp.fire |-> !short_i)
      else $error("group fired while the free list was short");

endmodule

// File: hdl/rename_out_buffer.sv
`timescale 1ns/100ps

module rename_out_buffer #(
   parameter type T = rename_pkg::group_out_t
) (
   input  logic clk,
   input  logic rst_n,
   input  logic push_i,
   input  T     data_i,
   input  logic stall_i,
   output logic valid_o,
   output T     data_o,
   output logic full_o
);

   // two entries, one-bit pointers toggle
   T           mem_q [2];
   logic       wr_q;
   logic       rd_q;
   logic [1:0] cnt_q;
   logic       pop;

   assign valid_o = cnt_q != 2'd0;
   assign full_o  = cnt_q == 2'd2;
   assign data_o  = mem_q[rd_q];
   assign pop     = valid_o && !stall_i;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_q  <= 1'b0;
         rd_q  <= 1'b0;
         cnt_q <= 2'd0;
      end
      else
      begin
         wr_q  <= wr_q ^ push_i;
         rd_q  <= rd_q ^ pop;
         cnt_q <= cnt_q + {1'b0, push_i} - {1'b0, pop};
      end
   end

   always_ff @(posedge clk)
   begin
      if (push_i)
         mem_q[wr_q] <= data_i;
   end

   // the intake checked full a cycle before firing
   a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
      push_i |-> !full_o)
      else $error("push into a full output buffer");

endmodule

// File: hdl/rename_pkg.sv
package rename_pkg;

   // group width and register file sizes
   localparam int NUM_SLOTS = 4;
   localparam int NUM_ARCH  = 16;
   localparam int NUM_PHYS  = 64;

   typedef logic [$clog2(NUM_ARCH)-1:0] arch_t;
   typedef logic [$clog2(NUM_PHYS)-1:0] phys_t;

   // list index plus one wrap bit
   typedef logic [$clog2(NUM_PHYS):0] ptr_t;

   typedef struct packed {
      logic  valid;
      logic  has_dst;
      arch_t dst;
      arch_t src0;
      arch_t src1;
   } slot_in_t;

   typedef struct packed {
      logic  valid;
      logic  has_dst;
      phys_t new_dst;
      phys_t old_dst;
      phys_t src0;
      phys_t src1;
   } slot_out_t;

   typedef slot_out_t [NUM_SLOTS-1:0] group_out_t;

   // entries below count are used, lowest first
   typedef struct packed {
      phys_t [NUM_SLOTS-1:0] entry;
      logic [2:0]            count;
   } free_bundle_t;

endpackage

// File: hdl/rename_top.sv
`timescale 1ns/100ps

module rename_top (
   input  logic                                             clk,
   input  logic                                             rst_n,
   input  logic                                             group_valid_i,
   input  rename_pkg::slot_in_t [rename_pkg::NUM_SLOTS-1:0] slots_i,
   input  logic [rename_pkg::NUM_SLOTS-1:0]                 retire_valid_i,
   input  rename_pkg::phys_t [rename_pkg::NUM_SLOTS-1:0]    retire_phys_i,
   input  logic                                             stall_i,
   output logic                                             hold_o,
   output logic                                             out_valid_o,
   output rename_pkg::group_out_t                           out_group_o
);

   logic                                          list_short;
   logic                                          buf_full;
   rename_pkg::phys_t [rename_pkg::NUM_SLOTS-1:0] alloc;
   rename_pkg::free_bundle_t                      free_bundle;
   rename_pkg::group_out_t                        renamed;

   rename_group_if grp_if ();

   rename_intake intake0 (
      .clk            (clk),
      .rst_n          (rst_n),
      .group_valid_i  (group_valid_i),
      .slots_i        (slots_i),
      .retire_valid_i (retire_valid_i),
      .retire_phys_i  (retire_phys_i),
      .short_i        (list_short),
      .full_i         (buf_full),
      .hold_o         (hold_o),
      .free_o         (free_bundle),
      .grp            (grp_if.intake)
   );

   free_list free_list0 (
      .clk     (clk),
      .rst_n   (rst_n),
      .grp     (grp_if.rename),
      .free_i  (free_bundle),
      .alloc_o (alloc),
      .short_o (list_short)
   );

   map_table map_table0 (
      .clk     (clk),
      .rst_n   (rst_n),
      .grp     (grp_if.rename),
      .alloc_i (alloc),
      .group_o (renamed)
   );

   rename_out_buffer #(.T(rename_pkg::group_out_t)) buf0 (
      .clk     (clk),
      .rst_n   (rst_n),
      .push_i  (grp_if.fire),
      .data_i  (renamed),
      .stall_i (stall_i),
      .valid_o (out_valid_o),
      .data_o  (out_group_o),
      .full_o  (buf_full)
   );

endmodule

// File: project.f
+incdir+include
hdl/rename_pkg.sv
hdl/rename_group_if.sv
hdl/rename_intake.sv
hdl/free_list.sv
hdl/map_table.sv
hdl/rename_out_buffer.sv
hdl/rename_top.sv
tests/rename_tb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the rename testbench with Verilator, runs it and checks the log
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f project.f \
   --top-module rename_tb \
   -o rename_sim

./obj_dir/rename_sim | tee sim.log

if grep -qx "Test OK" sim.log
then
   echo "simulation passed"
else
   echo "simulation failed, see sim.log"
   exit 1
fi

// File: include/rename_model.svh
`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

// expected state, advanced one consumed group at a time
rename_pkg::phys_t model_map [rename_pkg::NUM_ARCH];
rename_pkg::phys_t free_q [$];
rename_pkg::phys_t pending_q [$];
logic [31:0]       lcg_state = 32'h513cf8e4;
int                alloc_total = 0;

// value from 0 to n-1, taken from the upper bits of the generator
function automatic int rand_below(input int n);
   lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
   return int'(lcg_state[31:16]) % n;
endfunction

function automatic void model_reset();
   free_q.delete();
   pending_q.delete();
   for (int r = 0; r < rename_pkg::NUM_ARCH; r++)
      model_map[r] = rename_pkg::phys_t'(r);
   for (int p = rename_pkg::NUM_ARCH; p < rename_pkg::NUM_PHYS; p++)
      free_q.push_back(rename_pkg::phys_t'(p));
endfunction

// slots applied in order, so a source sees every earlier write of the group
function automatic rename_pkg::group_out_t expect_group(
   input rename_pkg::slot_in_t [rename_pkg::NUM_SLOTS-1:0] g
);
   rename_pkg::group_out_t e;
   e = '0;
   for (int k = 0; k < rename_pkg::NUM_SLOTS; k++)
   begin
      e[k].valid   = g[k].valid;
      e[k].has_dst = g[k].has_dst;
      e[k].src0    = model_map[g[k].src0];
      e[k].src1    = model_map[g[k].src1];
      if (g[k].valid && g[k].has_dst)
      begin
         e[k].old_dst = model_map[g[k].dst];
         e[k].new_dst = free_q.pop_front();
         model_map[g[k].dst] = e[k].new_dst;
         // the reorder buffer hands this one back later
         pending_q.push_back(e[k].old_dst);
         alloc_total++;
      end
   end
   return e;
endfunction

`endif

// File: tests/rename_tb.sv
`timescale 1ns/100ps

module rename_tb;

   logic                                             clk;
   logic                                             rst_n;
   logic                                             group_valid_i;
   rename_pkg::slot_in_t [rename_pkg::NUM_SLOTS-1:0] slots_i;
   logic [rename_pkg::NUM_SLOTS-1:0]                 retire_valid_i;
   rename_pkg::phys_t [rename_pkg::NUM_SLOTS-1:0]    retire_phys_i;
   logic                                             stall_i;
   logic                                             hold_o;
   logic                                             out_valid_o;
   rename_pkg::group_out_t                           out_group_o;

   `include "rename_model.svh"

   // groups sampled by the DUT and not yet checked
   rename_pkg::slot_in_t [rename_pkg::NUM_SLOTS-1:0] sent_q [$];
   rename_pkg::group_out_t                           held;
   logic offering = 1'b0;
   logic taken = 1'b0;
   logic was_stalled = 1'b0;
   logic got_out = 1'b0;
   logic force_stall = 1'b0;
   logic dense = 1'b0;
   int   groups_left = 0;
   int   offer_pct = 100;
   int   stall_pct = 0;
   int   retire_pct = 0;
   int   retire_max = 4;
   int   reg_span = 16;
   int   errors = 0;
   int   tests_passed = 0;
   int   tests_failed = 0;

   rename_top dut0 (
      .clk            (clk),
      .rst_n          (rst_n),
      .group_valid_i  (group_valid_i),
      .slots_i        (slots_i),
      .retire_valid_i (retire_valid_i),
      .retire_phys_i  (retire_phys_i),
      .stall_i        (stall_i),
      .hold_o         (hold_o),
      .out_valid_o    (out_valid_o),
      .out_group_o    (out_group_o)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic check_value(input string name, input int got, input int exp);
      assert (got == exp)
      else
      begin
         $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_field(input int k, input string field, input int got, input int exp);
      check_value($sformatf("out_group_o[%0d].%s", k, field), got, exp);
   endtask

   // compare the group at the output with the next one the model renames
   task automatic consume_group();
      rename_pkg::slot_in_t [rename_pkg::NUM_SLOTS-1:0] g;
      rename_pkg::group_out_t                           e;
      if (sent_q.size() == 0)
      begin
         $display("%0t: a group came out that was never sent", $time);
         errors++;
         return;
      end
      g = sent_q.pop_front();
      assert (free_q.size() >= rename_pkg::NUM_SLOTS)
      else
      begin
         $display("%0t: a group came out with only %0d registers free", $time, free_q.size());
         errors++;
         return;
      end
      e = expect_group(g);
      for (int k = 0; k < rename_pkg::NUM_SLOTS; k++)
      begin
         check_field(k, "valid", int'(out_group_o[k].valid), int'(e[k].valid));
         check_field(k, "has_dst", int'(out_group_o[k].has_dst), int'(e[k].has_dst));
         if (e[k].valid)
         begin
            check_field(k, "src0", int'(out_group_o[k].src0), int'(e[k].src0));
            check_field(k, "src1", int'(out_group_o[k].src1), int'(e[k].src1));
         end
         if (e[k].valid && e[k].has_dst)
         begin
            check_field(k, "new_dst", int'(out_group_o[k].new_dst), int'(e[k].new_dst));
            check_field(k, "old_dst", int'(out_group_o[k].old_dst), int'(e[k].old_dst));
         end
      end
   endtask

   task automatic make_group();
      for (int k = 0; k < rename_pkg::NUM_SLOTS; k++)
      begin
         slots_i[k].valid   = dense || rand_below(8) != 0;
         slots_i[k].has_dst = dense || rand_below(4) != 0;
         slots_i[k].dst     = rename_pkg::arch_t'(rand_below(reg_span));
         slots_i[k].src0    = rename_pkg::arch_t'(rand_below(reg_span));
         slots_i[k].src1    = rename_pkg::arch_t'(rand_below(reg_span));
      end
   endtask

   // unused slots carry junk, so the packing is exercised
   task automatic drive_retire();
      int n;
      n = 0;
      retire_valid_i = '0;
      for (int k = 0; k < rename_pkg::NUM_SLOTS; k++)
         retire_phys_i[k] = rename_pkg::phys_t'(rand_below(rename_pkg::NUM_PHYS));
      if (rand_below(100) < retire_pct)
      begin
         for (int k = 0; k < rename_pkg::NUM_SLOTS; k++)
         begin
            if (rand_below(2) == 1 && n < retire_max && pending_q.size() > 0)
            begin
               retire_valid_i[k] = 1'b1;
               retire_phys_i[k]  = pending_q.pop_front();
               free_q.push_back(retire_phys_i[k]);
               n++;
            end
         end
      end
   endtask

   // observe outputs just after the edge and drive the next inputs
   task automatic step();
      @(posedge clk);
      #1;
      got_out = 1'b0;
      if (was_stalled)
      begin
         check_value("out_valid_o", int'(out_valid_o), 1);
         assert (out_group_o == held)
         else
         begin
            $display("MISMATCH at %0t: out_group_o got %h expected %h",
                     $time, out_group_o, held);
            errors++;
         end
      end
      stall_i = force_stall || rand_below(100) < stall_pct;
      if (out_valid_o && !stall_i)
      begin
         consume_group();
         got_out = 1'b1;
      end
      was_stalled = out_valid_o && stall_i;
      held = out_group_o;
      if (taken)
         offering = 1'b0;
      if (!offering && groups_left > 0 && rand_below(100) < offer_pct)
      begin
         make_group();
         offering = 1'b1;
         groups_left--;
      end
      group_valid_i = offering;
      // hold_o is stable here, so the coming edge takes the group or not
      taken = offering && !hold_o;
      if (taken)
         sent_q.push_back(slots_i);
      drive_retire();
   endtask

   task automatic drain(input int limit);
      int n;
      n = 0;
      while ((groups_left > 0 || offering || sent_q.size() != 0) && n < limit)
      begin
         step();
         n++;
      end
      if (groups_left > 0 || offering || sent_q.size() != 0)
      begin
         $display("timeout: %0d groups still in flight after %0d cycles", sent_q.size(), n);
         errors++;
      end
   endtask

   task automatic end_test(input string name, input int errs_before);
      if (errors == errs_before)
      begin
         tests_passed++;
         $display("%s: pass", name);
      end
      else
      begin
         tests_failed++;
         $display("%s: fail with %0d errors", name, errors - errs_before);
      end
   endtask

   initial
   begin
      int mark;
      int lat;
      int guard;
      int alloc_mark;
      rst_n          = 1'b0;
      group_valid_i  = 1'b0;
      slots_i        = '0;
      retire_valid_i = '0;
      retire_phys_i  = '0;
      stall_i        = 1'b0;
      model_reset();
      repeat (8) @(posedge clk);
      #1;
      rst_n = 1'b1;

      mark = errors;
      check_value("out_valid_o", int'(out_valid_o), 0);
      check_value("hold_o", int'(hold_o), 0);
      dense = 1'b1;
      groups_left = 1;
      step();
      lat = 0;
      step();
      while (!got_out && lat < 20)
      begin
         step();
         lat++;
      end
      if (!got_out)
      begin
         $display("timeout: the first group never came out");
         errors++;
      end
      check_value("output latency", lat, 2);
      end_test("reset and first allocation", mark);

      // narrow register range forces repeats inside a group
      mark = errors;
      dense = 1'b0;
      reg_span = 4;
      offer_pct = 70;
      retire_pct = 50;
      groups_left = 60;
      drain(2000);
      end_test("bypass and old mappings", mark);

      mark = errors;
      reg_span = 16;
      stall_pct = 50;
      offer_pct = 80;
      groups_left = 60;
      drain(3000);
      // long stall fills the buffer, then the intake
      force_stall = 1'b1;
      offer_pct = 100;
      groups_left = 6;
      repeat (12) step();
      check_value("hold_o", int'(hold_o), 1);
      force_stall = 1'b0;
      stall_pct = 0;
      drain(500);
      end_test("stall and ordering", mark);

      mark = errors;
      retire_pct = 0;
      dense = 1'b1;
      repeat (4) step();
      guard = 0;
      while (free_q.size() >= rename_pkg::NUM_SLOTS && guard < 20)
      begin
         groups_left = 1;
         drain(50);
         guard++;
      end
      groups_left = 1;
      repeat (20)
      begin
         step();
         check_value("out_valid_o", int'(out_valid_o), 0);
      end
      check_value("hold_o", int'(hold_o), 1);
      // single returns until the stuck group may go
      retire_pct = 40;
      retire_max = 1;
      drain(400);
      end_test("exhaustion", mark);

      mark = errors;
      alloc_mark = alloc_total;
      dense = 1'b0;
      retire_max = 4;
      retire_pct = 60;
      stall_pct = 20;
      offer_pct = 90;
      groups_left = 80;
      drain(4000);
      assert (alloc_total - alloc_mark > rename_pkg::NUM_PHYS)
      else
      begin
         $display("the free list never wrapped, only %0d allocations in this test",
                  alloc_total - alloc_mark);
         errors++;
      end
      end_test("reuse after wrap", mark);

      $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
      if (errors == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule
